//--- Bender.yml
package:
  name: mmio_subsystem

sources:
  - files:
      - ioMapPkg.sv
      - ioDevPkg.sv
      - ioBusFront.sv
      - segQueue.sv
      - indicatorCtrl.sv
      - mmioSubsystem.sv
  - target: test
    files:
      - mmioSubsystem_asserts.sv
      - tbMmioSubsystem.sv

//--- indicatorCtrl.sv
`timescale 1ns/1ps

module indicatorCtrl
  import ioDevPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  ioWrStb_t wrStb,
  output ledWord_t ledOut,
  output logic     blinkOut
);

  // Cycles left with blink high
  blinkCnt_t blinkCnt;
  blinkCnt_t blinkNext;

  //////////////////////////////////////////////////
  // Blink countdown
  //////////////////////////////////////////////////

  // Store reloads at once, else count down to zero
  always_comb begin
    blinkNext = blinkCnt;
    if (wrStb.blinkWr) begin
      blinkNext = blinkCnt_t'(wrStb.data);
    end else if (blinkCnt != '0) begin
      blinkNext = blinkCnt - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ledOut   <= '0;
      blinkCnt <= '0;
      blinkOut <= 1'b0;
    end else begin
      // Low half of the store word
      if (wrStb.ledWr) begin
        ledOut <= wrStb.data[LED_W-1:0];
      end
      blinkCnt <= blinkNext;
      // High while the updated count is nonzero
      // N loaded gives N high cycles
      blinkOut <= (blinkNext != '0);
    end
  end

endmodule

//--- ioBusFront.sv
`timescale 1ns/1ps

module ioBusFront
  import ioMapPkg::*, ioDevPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  ioReq_t    req,
  input  busWord_t  memRdata,
  input  swByte_t   swIn,
  input  logic      enterA,
  input  logic      enterB,
  input  testBits_t testIn,
  output busWord_t  loadData,
  output ioWrStb_t  wrStb
);

  // One compare per mapped address
  logic hitSwA;
  logic hitSwB;
  logic hitTest;
  logic hitSeg;
  logic hitLed;
  logic hitBlink;

  // Captured switch bytes
  swByte_t swA;
  swByte_t swB;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Full 32-bit match, no aliasing
  assign hitSwA   = (req.addr == ADDR_SW_A);
  assign hitSwB   = (req.addr == ADDR_SW_B);
  assign hitTest  = (req.addr == ADDR_TEST);
  assign hitSeg   = (req.addr == ADDR_SEG);
  assign hitLed   = (req.addr == ADDR_LED);
  assign hitBlink = (req.addr == ADDR_BLINK);

  // Store strobes
  // addresses differ, so at most one is set
  always_comb begin
    wrStb.segWr   = req.write && hitSeg;
    wrStb.ledWr   = req.write && hitLed;
    wrStb.blinkWr = req.write && hitBlink;
    // Data rides along unqualified
    wrStb.data    = req.wdata;
  end

  //////////////////////////////////////////////////
  // Switch capture
  //////////////////////////////////////////////////

  // Both bytes share the one switch bank
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      swA <= '0;
      swB <= '0;
    end else begin
      // Level sampled, held while button is down
      if (enterA) begin
        swA <= swIn;
      end
      if (enterB) begin
        swB <= swIn;
      end
    end
  end

  //////////////////////////////////////////////////
  // Load result
  //////////////////////////////////////////////////

  // Zero latency, memory word is the fallback
  always_comb begin
    loadData = memRdata;
    if (req.read) begin
      if (hitSwA) begin
        loadData = busWord_t'(swA);
      end else if (hitSwB) begin
        loadData = busWord_t'(swB);
      end else if (hitTest) begin
        // Test pins read live, not captured
        loadData = busWord_t'(testIn);
      end
    end
  end

endmodule

//--- ioDevPkg.sv
package ioDevPkg;

  import ioMapPkg::*;

  //////////////////////////////////////////////////
  // Device-side field widths
  //////////////////////////////////////////////////

  localparam int unsigned SW_W    = 8;
  localparam int unsigned TEST_W  = 3;
  localparam int unsigned SEG_W   = 24;
  localparam int unsigned LED_W   = 16;
  localparam int unsigned BLINK_W = 32;

  // Operator switch byte
  typedef logic [SW_W-1:0]    swByte_t;
  // Test input pins
  typedef logic [TEST_W-1:0]  testBits_t;
  // Segment word, low bits of the store data
  typedef logic [SEG_W-1:0]   segWord_t;
  // LED pattern, low bits of the store data
  typedef logic [LED_W-1:0]   ledWord_t;
  // Blink countdown in clock cycles
  typedef logic [BLINK_W-1:0] blinkCnt_t;

  // Decoded store, at most one strobe set per cycle
  typedef struct packed {
    logic     segWr;
    logic     ledWr;
    logic     blinkWr;
    busWord_t data;
  } ioWrStb_t;

endpackage

//--- ioMapPkg.sv
package ioMapPkg;

  //////////////////////////////////////////////////
  // Load/store path widths
  //////////////////////////////////////////////////

  // CPU side is a plain 32-bit byte-addressed bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Byte address straight from the ALU
  typedef logic [ADDR_W-1:0] busAddr_t;

  // Load result or store data
  typedef logic [DATA_W-1:0] busWord_t;

  // One cycle's access, read and write are single-cycle levels
  typedef struct packed {
    logic     read;
    logic     write;
    busAddr_t addr;
    busWord_t wdata;
  } ioReq_t;

  //////////////////////////////////////////////////
  // I/O window in the top kilobyte
  //////////////////////////////////////////////////

  // Input side, read only
  localparam busAddr_t ADDR_SW_A  = 32'hFFFF_FC00;
  localparam busAddr_t ADDR_SW_B  = 32'hFFFF_FC04;
  localparam busAddr_t ADDR_TEST  = 32'hFFFF_FC08;

  // Output side, write only
  localparam busAddr_t ADDR_SEG   = 32'hFFFF_FC10;
  localparam busAddr_t ADDR_LED   = 32'hFFFF_FC14;
  localparam busAddr_t ADDR_BLINK = 32'hFFFF_FC18;

endpackage

//--- mmioSubsystem.f
ioMapPkg.sv
ioDevPkg.sv
ioBusFront.sv
segQueue.sv
indicatorCtrl.sv
mmioSubsystem.sv
mmioSubsystem_asserts.sv
tbMmioSubsystem.sv

//--- mmioSubsystem.sv
`timescale 1ns/1ps

module mmioSubsystem
  import ioMapPkg::*, ioDevPkg::*;
#(
  parameter int unsigned DWELL_CYCLES = 50_000_000,
  parameter int unsigned QUEUE_DEPTH  = 256
) (
  input  logic      clk,
  input  logic      rstN,
  input  ioReq_t    req,
  input  busWord_t  memRdata,
  input  swByte_t   swIn,
  input  logic      enterA,
  input  logic      enterB,
  input  testBits_t testIn,
  output busWord_t  loadData,
  output segWord_t  segOut,
  output ledWord_t  ledOut,
  output logic      blinkOut
);

  // Decoded store, shared by both output blocks
  ioWrStb_t wrStb;

  //////////////////////////////////////////////////
  // Input side and decode
  //////////////////////////////////////////////////

  ioBusFront u_ioBusFront (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .memRdata (memRdata),
    .swIn     (swIn),
    .enterA   (enterA),
    .enterB   (enterB),
    .testIn   (testIn),
    .loadData (loadData),
    .wrStb    (wrStb)
  );

  //////////////////////////////////////////////////
  // Output blocks
  //////////////////////////////////////////////////

  segQueue #(
    .DWELL_CYCLES (DWELL_CYCLES),
    .QUEUE_DEPTH  (QUEUE_DEPTH)
  ) u_segQueue (
    .clk    (clk),
    .rstN   (rstN),
    .wrStb  (wrStb),
    .segOut (segOut)
  );

  indicatorCtrl u_indicatorCtrl (
    .clk      (clk),
    .rstN     (rstN),
    .wrStb    (wrStb),
    .ledOut   (ledOut),
    .blinkOut (blinkOut)
  );

endmodule

//--- mmioSubsystem_asserts.sv
`timescale 1ns/1ps

module mmioSubsystem_asserts
  import ioDevPkg::*;
(
  input logic      clk,
  input logic      rstN,
  input segWord_t  segOut,
  input ledWord_t  ledOut,
  input logic      blinkOut,
  input logic      queueEmpty,
  input segWord_t  headWord,
  input blinkCnt_t blinkCnt,
  input logic      blinkWr
);

  // Read by the testbench at the end
  int unsigned failCount = 0;

  // First edge out of reset sees cleared outputs
  resetClearA: assert property (@(posedge clk)
    $rose(rstN) |-> (segOut == '0) && (ledOut == '0) && !blinkOut)
    else begin
      $error("outputs not clear when reset was released");
      failCount++;
    end

  // Display shows the stored head entry or blank when nothing is queued
  emptyBlankA: assert property (@(posedge clk) disable iff (!rstN)
    segOut == (queueEmpty ? segWord_t'(0) : headWord))
    else begin
      $error("segOut does not match the queue head");
      failCount++;
    end

  // Fall only on the last count or a reload
  blinkHoldA: assert property (@(posedge clk) disable iff (!rstN)
    $fell(blinkOut) |-> ($past(blinkCnt) == blinkCnt_t'(1)) || $past(blinkWr))
    else begin
      $error("blinkOut fell before its count ran out");
      failCount++;
    end

endmodule

bind mmioSubsystem mmioSubsystem_asserts u_asserts (
  .clk        (clk),
  .rstN       (rstN),
  .segOut     (segOut),
  .ledOut     (ledOut),
  .blinkOut   (blinkOut),
  .queueEmpty (u_segQueue.fillCnt == '0),
  .headWord   (u_segQueue.segMem[u_segQueue.headPtr]),
  .blinkCnt   (u_indicatorCtrl.blinkCnt),
  .blinkWr    (wrStb.blinkWr)
);

//--- segQueue.sv
`timescale 1ns/1ps

module segQueue
  import ioDevPkg::*;
#(
  parameter int unsigned DWELL_CYCLES = 50_000_000,
  // Power of two, at least 2
  parameter int unsigned QUEUE_DEPTH  = 256
) (
  input  logic     clk,
  input  logic     rstN,
  input  ioWrStb_t wrStb,
  output segWord_t segOut
);

  localparam int unsigned PTR_W   = $clog2(QUEUE_DEPTH);
  // One extra bit so full and empty differ
  localparam int unsigned CNT_W   = $clog2(QUEUE_DEPTH + 1);
  localparam int unsigned DWELL_W = $clog2(DWELL_CYCLES + 1);

  typedef logic [PTR_W-1:0]   qPtr_t;
  typedef logic [CNT_W-1:0]   qCnt_t;
  typedef logic [DWELL_W-1:0] dwell_t;

  localparam qCnt_t  DEPTH_CNT  = qCnt_t'(QUEUE_DEPTH);
  localparam dwell_t DWELL_LAST = dwell_t'(DWELL_CYCLES - 1);

  // Entry storage
  segWord_t segMem [QUEUE_DEPTH];

  qPtr_t    headPtr;
  qPtr_t    tailPtr;
  qCnt_t    fillCnt;
  dwell_t   dwellCnt;

  logic     push;
  logic     pop;
  qPtr_t    headNext;
  qCnt_t    fillNext;
  segWord_t wrWord;
  segWord_t headWordNext;

  //////////////////////////////////////////////////
  // Push and pop decisions
  //////////////////////////////////////////////////

  assign wrWord = wrStb.data[SEG_W-1:0];

  // Full judged before this edge's pop
  assign push = wrStb.segWr && (fillCnt != DEPTH_CNT);

  // Head has been up for its whole dwell
  assign pop = (fillCnt != '0) && (dwellCnt == DWELL_LAST);

  assign headNext = pop ? qPtr_t'(headPtr + 1'b1) : headPtr;

  always_comb begin
    fillNext = fillCnt;
    case ({push, pop})
      2'b10:   fillNext = fillCnt + 1'b1;
      2'b01:   fillNext = fillCnt - 1'b1;
      default: fillNext = fillCnt;
    endcase
  end

  // Next head may be the word landing this edge
  // only possible when the queue drains to empty
  assign headWordNext = (push && (headNext == tailPtr)) ? wrWord : segMem[headNext];

  //////////////////////////////////////////////////
  // Pointers, dwell timer, output
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      headPtr  <= '0;
      tailPtr  <= '0;
      fillCnt  <= '0;
      dwellCnt <= '0;
      segOut   <= '0;
    end else begin
      if (push) begin
        tailPtr <= tailPtr + 1'b1;
      end
      headPtr <= headNext;
      fillCnt <= fillNext;
      // Restart for every new head, idle while empty
      if (pop || (fillCnt == '0)) begin
        dwellCnt <= '0;
      end else begin
        dwellCnt <= dwellCnt + 1'b1;
      end
      // Blank display when nothing is queued
      segOut <= (fillNext != '0) ? headWordNext : '0;
    end
  end

  // Storage write port
  always_ff @(posedge clk) begin
    if (push) begin
      segMem[tailPtr] <= wrWord;
    end
  end

endmodule

//--- tbMmioSubsystem.sv
`timescale 1ns/1ps

module tbMmioSubsystem
  import ioMapPkg::*, ioDevPkg::*;
;

  localparam int CLK_PERIOD = 10;
  localparam int DWELL      = 4;
  localparam int DEPTH      = 4;

  // Cycle budget per test summed for the watchdog
  localparam int LOAD_CYCLES  = 12;
  localparam int LED_CYCLES   = 6;
  localparam int BLINK_CYCLES = 40;
  localparam int ORDER_CYCLES = 3 * (DWELL + 1) + 3;
  localparam int OVF_CYCLES   = 6 * (DWELL + 1) + 3;
  localparam int RESET_CYCLES = 10 + DWELL;
  localparam int BUDGET = 3 + LOAD_CYCLES + LED_CYCLES + BLINK_CYCLES + ORDER_CYCLES
                          + OVF_CYCLES + RESET_CYCLES + 50;

  logic      clk;
  logic      rstN;
  ioReq_t    req;
  busWord_t  memRdata;
  swByte_t   swIn;
  logic      enterA;
  logic      enterB;
  testBits_t testIn;
  busWord_t  loadData;
  segWord_t  segOut;
  ledWord_t  ledOut;
  logic      blinkOut;

  int unsigned errCount;
  logic [31:0] rngState;

  // Segment queue reference with the head first
  segWord_t modelQ[$];
  int       modelDwell;

  mmioSubsystem #(
    .DWELL_CYCLES (DWELL),
    .QUEUE_DEPTH  (DEPTH)
  ) u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .memRdata (memRdata),
    .swIn     (swIn),
    .enterA   (enterA),
    .enterB   (enterB),
    .testIn   (testIn),
    .loadData (loadData),
    .segOut   (segOut),
    .ledOut   (ledOut),
    .blinkOut (blinkOut)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // 32-bit xorshift
  function automatic logic [31:0] nextRandom();
    logic [31:0] s;
    s = rngState;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rngState = s;
    return s;
  endfunction

  // One queue step per edge
  // full judged before the pop
  function automatic segWord_t stepModel(input logic wr, input segWord_t w);
    logic doPush;
    logic doPop;
    doPush = wr && (modelQ.size() < DEPTH);
    doPop  = (modelQ.size() > 0) && (modelDwell == DWELL - 1);
    if (doPop || (modelQ.size() == 0)) begin
      modelDwell = 0;
    end else begin
      modelDwell++;
    end
    if (doPop) begin
      void'(modelQ.pop_front());
    end
    if (doPush) begin
      modelQ.push_back(w);
    end
    return (modelQ.size() > 0) ? modelQ[0] : segWord_t'(0);
  endfunction

  task automatic driveIdle();
    req = '0;
  endtask

  task automatic driveStore(input busAddr_t addr, input busWord_t data);
    req.read  = 1'b0;
    req.write = 1'b1;
    req.addr  = addr;
    req.wdata = data;
  endtask

  task automatic checkWord(input string name, input busWord_t got, input busWord_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkSeg(input string name, input segWord_t got, input segWord_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkLed(input string name, input ledWord_t got, input ledWord_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  // Combinational load sampled shortly after the falling edge
  task automatic checkLoad(input busAddr_t addr, input logic rd, input logic fromMem,
                           input busWord_t ioWord);
    busWord_t expWord;
    @(negedge clk);
    memRdata  = nextRandom();
    req.read  = rd;
    req.write = 1'b0;
    req.addr  = addr;
    req.wdata = nextRandom();
    #2;
    expWord = fromMem ? memRdata : ioWord;
    checkWord("loadData", loadData, expWord);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic testLoads();
    swByte_t   byteA;
    swByte_t   byteB;
    testBits_t pins;
    byteA = swByte_t'(nextRandom());
    byteB = swByte_t'(nextRandom());
    pins  = testBits_t'(nextRandom());
    @(negedge clk);
    swIn   = byteA;
    enterA = 1'b1;
    @(negedge clk);
    enterA = 1'b0;
    swIn   = byteB;
    enterB = 1'b1;
    @(negedge clk);
    enterB = 1'b0;
    // Captured bytes hold while the switches move on
    swIn   = swByte_t'(nextRandom());
    testIn = pins;
    checkLoad(ADDR_SW_A, 1'b1, 1'b0, busWord_t'(byteA));
    checkLoad(ADDR_SW_B, 1'b1, 1'b0, busWord_t'(byteB));
    checkLoad(ADDR_TEST, 1'b1, 1'b0, busWord_t'(pins));
    checkLoad(32'hFFFF_FC0C, 1'b1, 1'b1, '0);
    checkLoad(ADDR_LED, 1'b1, 1'b1, '0);
    // Upper address bits cleared must not alias
    checkLoad(32'h0000_FC00, 1'b1, 1'b1, '0);
    checkLoad(ADDR_SW_A, 1'b0, 1'b1, '0);
    @(negedge clk);
    driveIdle();
  endtask

  task automatic testLeds();
    busWord_t data;
    ledWord_t expLed;
    data   = nextRandom();
    expLed = data[LED_W-1:0];
    @(negedge clk);
    driveStore(ADDR_LED, data);
    @(negedge clk);
    checkLed("ledOut", ledOut, expLed);
    driveStore(32'hFFFF_FC1C, nextRandom());
    @(negedge clk);
    checkLed("ledOut", ledOut, expLed);
    req.read  = 1'b1;
    req.write = 1'b0;
    req.addr  = ADDR_LED;
    @(negedge clk);
    checkLed("ledOut", ledOut, expLed);
    driveStore(32'h0000_FC14, nextRandom());
    @(negedge clk);
    checkLed("ledOut", ledOut, expLed);
    driveIdle();
  endtask

  // Store n, then expect n high cycles and two low ones
  task automatic blinkRun(input int n);
    int i;
    @(negedge clk);
    driveStore(ADDR_BLINK, busWord_t'(n));
    for (i = 0; i < n + 2; i++) begin
      @(negedge clk);
      driveIdle();
      checkBit("blinkOut", blinkOut, i < n);
    end
  endtask

  task automatic testBlink();
    int i;
    blinkRun(0);
    blinkRun(1);
    blinkRun(7);
    // Reload of 5 after three cycles of a 7 count
    @(negedge clk);
    driveStore(ADDR_BLINK, 32'd7);
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      checkBit("blinkOut", blinkOut, 1'b1);
      if (i == 3) begin
        driveStore(ADDR_BLINK, 32'd5);
      end else begin
        driveIdle();
      end
    end
    for (i = 0; i < 7; i++) begin
      @(negedge clk);
      driveIdle();
      checkBit("blinkOut", blinkOut, i < 5);
    end
  endtask

  // Back-to-back segment stores checked every cycle until drained
  task automatic segBurst(input int nStores);
    busWord_t data;
    segWord_t expSeg;
    int       cyc;
    modelQ.delete();
    modelDwell = 0;
    expSeg     = '0;
    for (cyc = 0; cyc < nStores * (DWELL + 1) + 3; cyc++) begin
      @(negedge clk);
      checkSeg("segOut", segOut, expSeg);
      if (cyc < nStores) begin
        data = nextRandom();
        driveStore(ADDR_SEG, data);
        expSeg = stepModel(1'b1, data[SEG_W-1:0]);
      end else begin
        driveIdle();
        expSeg = stepModel(1'b0, '0);
      end
    end
  endtask

  task automatic testSegOrder();
    segBurst(3);
  endtask

  // Fifth store meets a full queue
  // sixth lands after the first pop
  task automatic testSegOverflow();
    segBurst(6);
  endtask

  task automatic testReset();
    busWord_t data;
    int       i;
    @(negedge clk);
    driveStore(ADDR_SEG, nextRandom());
    @(negedge clk);
    driveStore(ADDR_SEG, nextRandom());
    @(negedge clk);
    driveStore(ADDR_LED, nextRandom() | 32'h1);
    @(negedge clk);
    driveStore(ADDR_BLINK, 32'd9);
    @(negedge clk);
    driveIdle();
    rstN = 1'b0;
    @(negedge clk);
    checkSeg("segOut", segOut, '0);
    checkLed("ledOut", ledOut, '0);
    checkBit("blinkOut", blinkOut, 1'b0);
    rstN = 1'b1;
    // New word up at once and alone with old entries gone
    data = nextRandom();
    @(negedge clk);
    driveStore(ADDR_SEG, data);
    for (i = 0; i < DWELL; i++) begin
      @(negedge clk);
      driveIdle();
      checkSeg("segOut", segOut, data[SEG_W-1:0]);
    end
    @(negedge clk);
    checkSeg("segOut", segOut, '0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk      = 1'b0;
    rstN     = 1'b0;
    req      = '0;
    memRdata = '0;
    swIn     = '0;
    enterA   = 1'b0;
    enterB   = 1'b0;
    testIn   = '0;
    errCount = 0;
    rngState = 32'hcd4c;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    testLoads();
    testLeds();
    testBlink();
    testSegOrder();
    testSegOverflow();
    testReset();
    repeat (2) @(negedge clk);
    $display("Done: %0d value errors, %0d assertion failures",
             errCount, u_dut.u_asserts.failCount);
    if ((errCount == 0) && (u_dut.u_asserts.failCount == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(BUDGET * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", BUDGET);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
